//--- cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] rt_code_t;

    typedef logic [2:0] alu_func_t;
    typedef logic [1:0] sft_func_t;
    typedef logic [1:0] regdst_t;
    typedef logic [2:0] branch_kind_t;
    typedef logic [1:0] jump_kind_t;
    typedef logic [1:0] mem_size_t;

    // Primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    // SPECIAL function field
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    // REGIMM selector in rt
    localparam rt_code_t RT_BLTZ   = 5'b00000;
    localparam rt_code_t RT_BGEZ   = 5'b00001;
    localparam rt_code_t RT_BLTZAL = 5'b10000;
    localparam rt_code_t RT_BGEZAL = 5'b10001;

    localparam alu_func_t ALU_ADD  = 3'd0;
    localparam alu_func_t ALU_SUB  = 3'd1;
    localparam alu_func_t ALU_SLT  = 3'd2;
    localparam alu_func_t ALU_SLTU = 3'd3;
    localparam alu_func_t ALU_AND  = 3'd4;
    localparam alu_func_t ALU_NOR  = 3'd5;
    localparam alu_func_t ALU_OR   = 3'd6;
    localparam alu_func_t ALU_XOR  = 3'd7;

    localparam sft_func_t SFT_LUI = 2'd0;
    localparam sft_func_t SFT_SLL = 2'd1;
    localparam sft_func_t SFT_SRA = 2'd2;
    localparam sft_func_t SFT_SRL = 2'd3;

    localparam regdst_t REGDST_RT = 2'd0;
    localparam regdst_t REGDST_RD = 2'd1;
    localparam regdst_t REGDST_RA = 2'd2; // Link register r31

    localparam branch_kind_t BR_EQ    = 3'd0;
    localparam branch_kind_t BR_NE    = 3'd1;
    localparam branch_kind_t BR_GEZ   = 3'd2;
    localparam branch_kind_t BR_GTZ   = 3'd3;
    localparam branch_kind_t BR_LEZ   = 3'd4;
    localparam branch_kind_t BR_LTZ   = 3'd5;
    localparam branch_kind_t BR_GEZAL = 3'd6;
    localparam branch_kind_t BR_LTZAL = 3'd7;

    localparam jump_kind_t JMP_J    = 2'd0;
    localparam jump_kind_t JMP_JR   = 2'd1;
    localparam jump_kind_t JMP_JAL  = 2'd2;
    localparam jump_kind_t JMP_JALR = 2'd3;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    typedef struct packed {
        opcode_t  op;
        rt_code_t rt_code;
        funct_t   funct;
    } instr_fields_t;

    typedef struct packed {
        logic equal; // rs == rt
        logic g0;    // rs > 0
        logic e0;    // rs == 0
    } cmp_flags_t;

    typedef struct packed {
        logic e;
        logic m;
        logic w;
    } stage_strobes_t;

    typedef struct packed {
        logic      alu_srcb_sel_rt;
        logic      sft_srcb_sel_rs;
        logic      sft_srca_sel_imm;
        logic      res_from_shift; // 0 ALU, 1 shifter
        alu_func_t alu_func;
        sft_func_t sft_func;
        logic      imm_sign;
        logic      intovf_en;
        logic      regwrite;
        regdst_t   regdst;
        logic      reserved_instr;
    } dp_ctrl_t;

    typedef struct packed {
        logic         isbranch;
        branch_kind_t branch;
        logic         isjump;
        jump_kind_t   jump;
        logic         link;
        logic         memreq;
        logic         memwr;
        mem_size_t    size;
        logic         rdata_sign;
        logic         memtoreg;
    } flow_ctrl_t;

    typedef struct packed {
        dp_ctrl_t   dp;
        flow_ctrl_t flow;
        logic       pcsrc;
    } ctrl_word_t;

endpackage

//--- instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  cpu_ctrl_pkg::instr_fields_t instr,
    output cpu_ctrl_pkg::dp_ctrl_t      dp
);

    import cpu_ctrl_pkg::*;

    always_comb
    begin
        dp = '0;
        case (instr.op)
            OP_SPECIAL:
            begin
                case (instr.funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                    FN_AND, FN_OR, FN_NOR, FN_XOR:
                    begin
                        dp.alu_srcb_sel_rt = 1'b1;
                        dp.regwrite        = 1'b1;
                        dp.regdst          = REGDST_RD;
                        dp.intovf_en       = (instr.funct == FN_ADD) || (instr.funct == FN_SUB);
                        case (instr.funct)
                            FN_SUB, FN_SUBU: dp.alu_func = ALU_SUB;
                            FN_SLT:          dp.alu_func = ALU_SLT;
                            FN_SLTU:         dp.alu_func = ALU_SLTU;
                            FN_AND:          dp.alu_func = ALU_AND;
                            FN_NOR:          dp.alu_func = ALU_NOR;
                            FN_OR:           dp.alu_func = ALU_OR;
                            FN_XOR:          dp.alu_func = ALU_XOR;
                            default:         dp.alu_func = ALU_ADD;
                        endcase
                    end
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:
                    begin
                        dp.res_from_shift  = 1'b1;
                        dp.sft_srcb_sel_rs = instr.funct[2]; // Amount from rs
                        dp.regwrite        = 1'b1;
                        dp.regdst          = REGDST_RD;
                        case (instr.funct)
                            FN_SLL, FN_SLLV: dp.sft_func = SFT_SLL;
                            FN_SRA, FN_SRAV: dp.sft_func = SFT_SRA;
                            default:         dp.sft_func = SFT_SRL;
                        endcase
                    end
                    FN_JR:
                    begin
                        dp.regwrite = 1'b0; // Target only
                    end
                    FN_JALR:
                    begin
                        dp.regwrite = 1'b1;
                        dp.regdst   = REGDST_RD;
                    end
                    default:
                    begin
                        dp.reserved_instr = 1'b1;
                    end
                endcase
            end

            OP_REGIMM:
            begin
                case (instr.rt_code)
                    RT_BLTZ, RT_BGEZ:
                    begin
                        dp.regwrite = 1'b0;
                    end
                    RT_BLTZAL, RT_BGEZAL:
                    begin
                        dp.regwrite = 1'b1; // Return address to r31
                        dp.regdst   = REGDST_RA;
                    end
                    default:
                    begin
                        dp.reserved_instr = 1'b1;
                    end
                endcase
            end

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI:
            begin
                dp.regwrite  = 1'b1;
                dp.regdst    = REGDST_RT;
                dp.imm_sign  = instr.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
                dp.intovf_en = (instr.op == OP_ADDI);
                case (instr.op)
                    OP_SLTI:  dp.alu_func = ALU_SLT;
                    OP_SLTIU: dp.alu_func = ALU_SLTU;
                    OP_ANDI:  dp.alu_func = ALU_AND;
                    OP_ORI:   dp.alu_func = ALU_OR;
                    OP_XORI:  dp.alu_func = ALU_XOR;
                    default:  dp.alu_func = ALU_ADD;
                endcase
            end

            OP_LUI:
            begin
                dp.res_from_shift   = 1'b1;
                dp.sft_srca_sel_imm = 1'b1;
                dp.sft_func         = SFT_LUI;
                dp.regwrite         = 1'b1;
                dp.regdst           = REGDST_RT;
            end

            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:
            begin
                dp.alu_func = ALU_ADD; // Address = rs + imm
                dp.imm_sign = 1'b1;
                dp.regwrite = 1'b1;
                dp.regdst   = REGDST_RT;
            end

            OP_SB, OP_SH, OP_SW:
            begin
                dp.alu_func = ALU_ADD;
                dp.imm_sign = 1'b1;
            end

            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J:
            begin
                dp.regwrite = 1'b0;
            end

            OP_JAL:
            begin
                dp.regwrite = 1'b1;
                dp.regdst   = REGDST_RA;
            end

            default:
            begin
                dp.reserved_instr = 1'b1;
            end
        endcase
    end

endmodule

//--- flow_decoder.sv
`timescale 1ns/100ps

module flow_decoder (
    input  cpu_ctrl_pkg::instr_fields_t instr,
    output cpu_ctrl_pkg::flow_ctrl_t    flow
);

    import cpu_ctrl_pkg::*;

    always_comb
    begin
        flow = '0;
        case (instr.op)
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
            begin
                flow.isbranch = 1'b1;
                case (instr.op)
                    OP_BNE:  flow.branch = BR_NE;
                    OP_BLEZ: flow.branch = BR_LEZ;
                    OP_BGTZ: flow.branch = BR_GTZ;
                    default: flow.branch = BR_EQ;
                endcase
            end

            OP_REGIMM:
            begin
                flow.isbranch = instr.rt_code inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
                flow.link     = instr.rt_code inside {RT_BLTZAL, RT_BGEZAL};
                case (instr.rt_code)
                    RT_BGEZ:   flow.branch = BR_GEZ;
                    RT_BLTZ:   flow.branch = BR_LTZ;
                    RT_BGEZAL: flow.branch = BR_GEZAL;
                    RT_BLTZAL: flow.branch = BR_LTZAL;
                    default:   flow.branch = BR_EQ; // Reserved, isbranch stays low
                endcase
            end

            OP_SPECIAL:
            begin
                flow.isjump = (instr.funct == FN_JR) || (instr.funct == FN_JALR);
                flow.link   = (instr.funct == FN_JALR);
                flow.jump   = (instr.funct == FN_JALR) ? JMP_JALR :
                              (instr.funct == FN_JR)   ? JMP_JR   : JMP_J;
            end

            OP_J, OP_JAL:
            begin
                flow.isjump = 1'b1;
                flow.link   = (instr.op == OP_JAL);
                flow.jump   = (instr.op == OP_JAL) ? JMP_JAL : JMP_J;
            end

            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW:
            begin
                flow.memreq     = 1'b1;
                flow.memwr      = instr.op[3]; // Stores are 101xxx
                flow.memtoreg   = !instr.op[3];
                flow.rdata_sign = instr.op inside {OP_LB, OP_LH, OP_LW};
                case (instr.op)
                    OP_LB, OP_LBU, OP_SB: flow.size = SIZE_BYTE;
                    OP_LH, OP_LHU, OP_SH: flow.size = SIZE_HALF;
                    default:              flow.size = SIZE_WORD;
                endcase
            end

            default:
            begin
                flow = '0;
            end
        endcase
    end

endmodule

//--- branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve (
    input  cpu_ctrl_pkg::flow_ctrl_t flow,
    input  cpu_ctrl_pkg::cmp_flags_t cmp,
    output logic                     taken
);

    import cpu_ctrl_pkg::*;

    logic cond;
    logic ge_zero;

    assign ge_zero = cmp.g0 | cmp.e0;

    always_comb
    begin
        case (flow.branch)
            BR_EQ:              cond = cmp.equal;
            BR_NE:              cond = !cmp.equal;
            BR_GEZ, BR_GEZAL:   cond = ge_zero;
            BR_GTZ:             cond = cmp.g0;
            BR_LEZ:             cond = !cmp.g0;
            default:            cond = !ge_zero; // LTZ and LTZAL
        endcase
    end

    assign taken = flow.isbranch & cond;

endmodule

//--- ctrl_pipeline.sv
`timescale 1ns/100ps

module ctrl_pipeline (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cpu_ctrl_pkg::ctrl_word_t     d_ctrl,
    input  cpu_ctrl_pkg::stage_strobes_t flush,
    input  cpu_ctrl_pkg::stage_strobes_t stall,
    output cpu_ctrl_pkg::ctrl_word_t     e_ctrl,
    output cpu_ctrl_pkg::ctrl_word_t     m_ctrl,
    output cpu_ctrl_pkg::ctrl_word_t     w_ctrl
);

    import cpu_ctrl_pkg::*;

    // Index 0 is execute, 1 memory, 2 writeback
    ctrl_word_t [2:0] stage_q;
    ctrl_word_t [2:0] stage_in;
    logic       [2:0] flush_v;
    logic       [2:0] stall_v;

    assign flush_v  = {flush.w, flush.m, flush.e};
    assign stall_v  = {stall.w, stall.m, stall.e};
    assign stage_in = {stage_q[1], stage_q[0], d_ctrl};

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            stage_q <= '0;
        end
        else
        begin
            for (int i = 0; i < 3; i++)
            begin
                if (flush_v[i])
                    stage_q[i] <= '0; // Flush wins over stall
                else if (!stall_v[i])
                    stage_q[i] <= stage_in[i];
            end
        end
    end

    assign e_ctrl = stage_q[0];
    assign m_ctrl = stage_q[1];
    assign w_ctrl = stage_q[2];

endmodule

//--- controller.sv
`timescale 1ns/100ps

module controller (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cpu_ctrl_pkg::instr_fields_t  instr,
    input  cpu_ctrl_pkg::cmp_flags_t     cmp,
    input  cpu_ctrl_pkg::stage_strobes_t flush,
    input  cpu_ctrl_pkg::stage_strobes_t stall,
    output cpu_ctrl_pkg::ctrl_word_t     d_ctrl,
    output cpu_ctrl_pkg::ctrl_word_t     e_ctrl,
    output cpu_ctrl_pkg::ctrl_word_t     m_ctrl,
    output cpu_ctrl_pkg::ctrl_word_t     w_ctrl
);

    import cpu_ctrl_pkg::*;

    dp_ctrl_t   dp;
    flow_ctrl_t flow;
    logic       taken;

    instr_decoder u_instr_decoder (
        .instr (instr),
        .dp    (dp)
    );

    flow_decoder u_flow_decoder (
        .instr (instr),
        .flow  (flow)
    );

    branch_resolve u_branch_resolve (
        .flow  (flow),
        .cmp   (cmp),
        .taken (taken)
    );

    assign d_ctrl = {dp, flow, taken}; // Decode stage word

    ctrl_pipeline u_ctrl_pipeline (
        .clk    (clk),
        .arst_n (arst_n),
        .d_ctrl (d_ctrl),
        .flush  (flush),
        .stall  (stall),
        .e_ctrl (e_ctrl),
        .m_ctrl (m_ctrl),
        .w_ctrl (w_ctrl)
    );

endmodule

//--- tb_controller_sva.sv
`timescale 1ns/100ps

module ctrl_sva (
    input logic                         clk,
    input logic                         arst_n,
    input cpu_ctrl_pkg::stage_strobes_t flush,
    input cpu_ctrl_pkg::ctrl_word_t     d_ctrl,
    input cpu_ctrl_pkg::ctrl_word_t     e_ctrl,
    input cpu_ctrl_pkg::ctrl_word_t     m_ctrl,
    input cpu_ctrl_pkg::ctrl_word_t     w_ctrl
);

    a_flush_clears_e: assert property (@(posedge clk) disable iff (!arst_n)
        flush.e |=> (e_ctrl == '0))
        else $error("e_ctrl not cleared one cycle after flush.e");

    a_pcsrc_needs_branch: assert property (@(posedge clk) disable iff (!arst_n)
        d_ctrl.pcsrc |-> d_ctrl.flow.isbranch)
        else $error("d_ctrl.pcsrc set without isbranch");

    a_pcsrc_needs_branch_e: assert property (@(posedge clk) disable iff (!arst_n)
        e_ctrl.pcsrc |-> e_ctrl.flow.isbranch)
        else $error("e_ctrl.pcsrc set without isbranch");

    a_store_no_write_d: assert property (@(posedge clk) disable iff (!arst_n)
        d_ctrl.flow.memwr |-> !d_ctrl.dp.regwrite)
        else $error("d_ctrl has memwr and regwrite together");

    a_store_no_write_m: assert property (@(posedge clk) disable iff (!arst_n)
        m_ctrl.flow.memwr |-> !m_ctrl.dp.regwrite)
        else $error("m_ctrl has memwr and regwrite together");

    a_store_no_write_w: assert property (@(posedge clk) disable iff (!arst_n)
        w_ctrl.flow.memwr |-> !w_ctrl.dp.regwrite)
        else $error("w_ctrl has memwr and regwrite together");

endmodule

bind ctrl_pipeline ctrl_sva u_ctrl_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .flush  (flush),
    .d_ctrl (d_ctrl),
    .e_ctrl (e_ctrl),
    .m_ctrl (m_ctrl),
    .w_ctrl (w_ctrl)
);

bind controller ctrl_sva u_ctrl_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .flush  (flush),
    .d_ctrl (d_ctrl),
    .e_ctrl (e_ctrl),
    .m_ctrl (m_ctrl),
    .w_ctrl (w_ctrl)
);

//--- tb_controller.sv
`timescale 1ns/100ps

module tb_controller;

    import cpu_ctrl_pkg::*;

    localparam int NUM_RESET   = 3;
    localparam int NUM_RANDOM  = 600;
    localparam int NUM_DRAIN   = 4;
    localparam int N_KEPT_FN   = 18;
    localparam int N_KEPT_OP   = 22;
    localparam int N_KEPT_RT   = 4;
    localparam int N_RSV_FN    = 10;
    localparam int N_RSV_OP    = 2;
    localparam int N_RSV_RT    = 2;
    localparam int TABLE_SIZE  = N_KEPT_FN + N_KEPT_OP + N_KEPT_RT + N_RSV_FN + N_RSV_OP
                               + N_RSV_RT;
    localparam int RUN_CYCLES  = NUM_RESET + TABLE_SIZE + NUM_RANDOM + NUM_DRAIN + 2;
    localparam int WATCHDOG_NS = RUN_CYCLES * 40 + 1000;

    localparam funct_t KEPT_FN [N_KEPT_FN] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
        FN_SLTU, FN_AND, FN_OR, FN_NOR, FN_XOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV,
        FN_SRAV, FN_JR, FN_JALR};
    localparam opcode_t KEPT_OP [N_KEPT_OP] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ,
        OP_BGTZ, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
    localparam rt_code_t KEPT_RT [N_KEPT_RT] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
    // MULT MULTU DIV DIVU MFHI MTHI MFLO MTLO SYSCALL BREAK
    localparam funct_t RSV_FN [N_RSV_FN] = '{6'h18, 6'h19, 6'h1a, 6'h1b, 6'h10, 6'h11,
        6'h12, 6'h13, 6'h0c, 6'h0d};
    localparam opcode_t RSV_OP [N_RSV_OP] = '{6'h10, 6'h1c}; // COP0, SPECIAL2
    localparam rt_code_t RSV_RT [N_RSV_RT] = '{5'h02, 5'h12};

    logic           clk;
    logic           arst_n;
    instr_fields_t  instr;
    cmp_flags_t     cmp;
    stage_strobes_t flush;
    stage_strobes_t stall;
    ctrl_word_t     d_ctrl;
    ctrl_word_t     e_ctrl;
    ctrl_word_t     m_ctrl;
    ctrl_word_t     w_ctrl;

    integer         seed;
    logic [31:0]    rnd;
    instr_fields_t  enc_table [$];
    ctrl_word_t     exp_d;
    ctrl_word_t     exp_e;
    ctrl_word_t     exp_m;
    ctrl_word_t     exp_w;
    ctrl_word_t     hist [1:3]; // Expected decode words, 1 to 3 cycles back
    int             plain_run;  // Edges in a row without strobes or reset
    int             decode_errors;
    int             pipe_errors;
    int             reset_errors;

    controller UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .instr  (instr),
        .cmp    (cmp),
        .flush  (flush),
        .stall  (stall),
        .d_ctrl (d_ctrl),
        .e_ctrl (e_ctrl),
        .m_ctrl (m_ctrl),
        .w_ctrl (w_ctrl)
    );

    always #20 clk = ~clk;

    function automatic ctrl_word_t ref_decode(input instr_fields_t f, input cmp_flags_t c);
        ctrl_word_t w;
        logic sp;
        logic ri;
        logic r_alu;
        logic r_sft;
        logic imm_alu;
        logic ld;
        logic st;
        logic known;
        w       = '0;
        sp      = (f.op == OP_SPECIAL);
        ri      = (f.op == OP_REGIMM);
        r_alu   = sp && (f.funct inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                                         FN_AND, FN_OR, FN_NOR, FN_XOR});
        r_sft   = sp && (f.funct inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV});
        imm_alu = f.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};
        ld      = f.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        st      = f.op inside {OP_SB, OP_SH, OP_SW};
        known   = r_alu || r_sft || imm_alu || ld || st
                  || (sp && (f.funct inside {FN_JR, FN_JALR}))
                  || (ri && (f.rt_code inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL}))
                  || (f.op inside {OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_LUI});
        if (!known)
        begin
            w.dp.reserved_instr = 1'b1; // Nothing else may act
            return w;
        end
        if (r_alu || imm_alu)
        begin
            w.dp.alu_srcb_sel_rt = r_alu;
            w.dp.regwrite        = 1'b1;
            w.dp.regdst          = r_alu ? REGDST_RD : REGDST_RT;
            w.dp.imm_sign        = f.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
            w.dp.intovf_en       = (r_alu && (f.funct inside {FN_ADD, FN_SUB}))
                                   || (f.op == OP_ADDI);
            if ((r_alu && (f.funct inside {FN_SUB, FN_SUBU})))
                w.dp.alu_func = ALU_SUB;
            else if ((r_alu && f.funct == FN_SLT) || f.op == OP_SLTI)
                w.dp.alu_func = ALU_SLT;
            else if ((r_alu && f.funct == FN_SLTU) || f.op == OP_SLTIU)
                w.dp.alu_func = ALU_SLTU;
            else if ((r_alu && f.funct == FN_AND) || f.op == OP_ANDI)
                w.dp.alu_func = ALU_AND;
            else if (r_alu && f.funct == FN_NOR)
                w.dp.alu_func = ALU_NOR;
            else if ((r_alu && f.funct == FN_OR) || f.op == OP_ORI)
                w.dp.alu_func = ALU_OR;
            else if ((r_alu && f.funct == FN_XOR) || f.op == OP_XORI)
                w.dp.alu_func = ALU_XOR;
        end
        if (r_sft)
        begin
            w.dp.res_from_shift  = 1'b1;
            w.dp.sft_srcb_sel_rs = f.funct inside {FN_SLLV, FN_SRLV, FN_SRAV};
            w.dp.regwrite        = 1'b1;
            w.dp.regdst          = REGDST_RD;
            if (f.funct inside {FN_SLL, FN_SLLV})
                w.dp.sft_func = SFT_SLL;
            else if (f.funct inside {FN_SRA, FN_SRAV})
                w.dp.sft_func = SFT_SRA;
            else
                w.dp.sft_func = SFT_SRL;
        end
        if (f.op == OP_LUI)
        begin
            w.dp.res_from_shift   = 1'b1;
            w.dp.sft_srca_sel_imm = 1'b1;
            w.dp.regwrite         = 1'b1;
            w.dp.regdst           = REGDST_RT;
        end
        if (ld || st)
        begin
            w.dp.imm_sign     = 1'b1;
            w.dp.regwrite     = ld;
            w.flow.memreq     = 1'b1;
            w.flow.memwr      = st;
            w.flow.memtoreg   = ld;
            w.flow.rdata_sign = f.op inside {OP_LB, OP_LH, OP_LW};
            if (f.op inside {OP_LB, OP_LBU, OP_SB})
                w.flow.size = SIZE_BYTE;
            else if (f.op inside {OP_LH, OP_LHU, OP_SH})
                w.flow.size = SIZE_HALF;
            else
                w.flow.size = SIZE_WORD;
        end
        if (f.op == OP_J || f.op == OP_JAL || (sp && (f.funct inside {FN_JR, FN_JALR})))
        begin
            w.flow.isjump = 1'b1;
            w.flow.link   = (f.op == OP_JAL) || (sp && f.funct == FN_JALR);
            w.dp.regwrite = w.flow.link;
            w.dp.regdst   = (f.op == OP_JAL) ? REGDST_RA :
                            (w.flow.link ? REGDST_RD : REGDST_RT);
            if (f.op == OP_JAL)
                w.flow.jump = JMP_JAL;
            else if (sp)
                w.flow.jump = (f.funct == FN_JR) ? JMP_JR : JMP_JALR;
        end
        if (f.op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ} || ri)
        begin
            w.flow.isbranch = 1'b1;
            w.flow.link     = ri && (f.rt_code inside {RT_BLTZAL, RT_BGEZAL});
            w.dp.regwrite   = w.flow.link;
            w.dp.regdst     = w.flow.link ? REGDST_RA : REGDST_RT;
            case ({ri, f.op == OP_BNE, f.op == OP_BLEZ, f.op == OP_BGTZ})
                4'b0100: w.flow.branch = BR_NE;
                4'b0010: w.flow.branch = BR_LEZ;
                4'b0001: w.flow.branch = BR_GTZ;
                4'b1000: w.flow.branch = (f.rt_code == RT_BLTZ)   ? BR_LTZ   :
                                         (f.rt_code == RT_BGEZ)   ? BR_GEZ   :
                                         (f.rt_code == RT_BLTZAL) ? BR_LTZAL : BR_GEZAL;
                default: w.flow.branch = BR_EQ;
            endcase
            case (w.flow.branch)
                BR_EQ:            w.pcsrc = c.equal;
                BR_NE:            w.pcsrc = !c.equal;
                BR_GEZ, BR_GEZAL: w.pcsrc = c.g0 || c.e0;
                BR_GTZ:           w.pcsrc = c.g0;
                BR_LEZ:           w.pcsrc = !c.g0;
                default:          w.pcsrc = !(c.g0 || c.e0);
            endcase
        end
        return w;
    endfunction

    function automatic instr_fields_t make_fields(input opcode_t op, input rt_code_t rt,
                                                  input funct_t fn);
        instr_fields_t f;
        f.op      = op;
        f.rt_code = rt;
        f.funct   = fn;
        return f;
    endfunction

    task automatic build_table();
        for (int i = 0; i < N_KEPT_FN; i++)
            enc_table.push_back(make_fields(OP_SPECIAL, 5'd0, KEPT_FN[i]));
        for (int i = 0; i < N_KEPT_OP; i++)
            enc_table.push_back(make_fields(KEPT_OP[i], 5'd0, 6'd0));
        for (int i = 0; i < N_KEPT_RT; i++)
            enc_table.push_back(make_fields(OP_REGIMM, KEPT_RT[i], 6'd0));
        for (int i = 0; i < N_RSV_FN; i++)
            enc_table.push_back(make_fields(OP_SPECIAL, 5'd0, RSV_FN[i]));
        for (int i = 0; i < N_RSV_OP; i++)
            enc_table.push_back(make_fields(RSV_OP[i], 5'd0, 6'd0));
        for (int i = 0; i < N_RSV_RT; i++)
            enc_table.push_back(make_fields(OP_REGIMM, RSV_RT[i], 6'd0));
    endtask

    // Fields that the opcode does not decode carry register or immediate bits
    task automatic fill_free_fields(inout instr_fields_t f);
        rnd = $random(seed);
        if (f.op != OP_SPECIAL)
            f.funct = rnd[5:0];
        if (f.op != OP_REGIMM)
            f.rt_code = rnd[12:8];
    endtask

    task automatic drive_cycle(input instr_fields_t f, input bit use_strobes);
        fill_free_fields(f);
        instr = f;
        rnd   = $random(seed);
        cmp   = rnd[2:0];
        flush = '0;
        stall = '0;
        if (use_strobes)
        begin
            flush.e = (rnd[10:8] == 3'd0);
            flush.m = (rnd[13:11] == 3'd0);
            flush.w = (rnd[16:14] == 3'd0);
            stall.e = (rnd[18:17] == 2'd0);
            stall.m = (rnd[20:19] == 2'd0);
            stall.w = (rnd[22:21] == 2'd0);
        end
    endtask

    task automatic pick_instr(output instr_fields_t f);
        int idx;
        rnd = $random(seed);
        if (rnd[2:0] == 3'd0)
        begin
            f = make_fields(rnd[8:3], rnd[13:9], rnd[19:14]); // Any opcode
        end
        else
        begin
            idx = int'({9'd0, rnd[30:8]}) % enc_table.size();
            f   = enc_table[idx];
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v, inout int count);
        if (act_v !== exp_v)
        begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            count++;
        end
    endtask

    task automatic advance_model();
        if (!arst_n)
        begin
            exp_e     = '0;
            exp_m     = '0;
            exp_w     = '0;
            plain_run = 0;
        end
        else
        begin
            if (flush.w)
                exp_w = '0;
            else if (!stall.w)
                exp_w = exp_m;
            if (flush.m)
                exp_m = '0;
            else if (!stall.m)
                exp_m = exp_e;
            if (flush.e)
                exp_e = '0;
            else if (!stall.e)
                exp_e = exp_d;
            if (flush == '0 && stall == '0)
                plain_run = (plain_run < 3) ? plain_run + 1 : 3;
            else
                plain_run = 0;
        end
        hist[3] = hist[2];
        hist[2] = hist[1];
        hist[1] = exp_d;
    endtask

    // Inputs change 2 ns after the rising edge, so the falling edge sees them settled
    always @(negedge clk)
    begin
        exp_d = ref_decode(instr, cmp);
        check_field("d_ctrl.dp", 32'(exp_d.dp), 32'(d_ctrl.dp), decode_errors);
        check_field("d_ctrl.flow", 32'(exp_d.flow), 32'(d_ctrl.flow), decode_errors);
        check_field("d_ctrl.pcsrc", 32'(exp_d.pcsrc), 32'(d_ctrl.pcsrc), decode_errors);
        if (d_ctrl.dp.reserved_instr && (d_ctrl.dp.regwrite || d_ctrl.flow.memreq
            || d_ctrl.flow.isbranch || d_ctrl.flow.isjump || d_ctrl.flow.link || d_ctrl.pcsrc))
        begin
            $display("Reserved encoding op %h rt %h funct %h left an action field active",
                     instr.op, instr.rt_code, instr.funct);
            decode_errors++;
        end
        check_field("e_ctrl", 32'(exp_e), 32'(e_ctrl), pipe_errors);
        check_field("m_ctrl", 32'(exp_m), 32'(m_ctrl), pipe_errors);
        check_field("w_ctrl", 32'(exp_w), 32'(w_ctrl), pipe_errors);
        if (plain_run >= 1)
            check_field("e_ctrl one cycle after d_ctrl", 32'(hist[1]), 32'(e_ctrl),
                        pipe_errors);
        if (plain_run >= 2)
            check_field("m_ctrl two cycles after d_ctrl", 32'(hist[2]), 32'(m_ctrl),
                        pipe_errors);
        if (plain_run >= 3)
            check_field("w_ctrl three cycles after d_ctrl", 32'(hist[3]), 32'(w_ctrl),
                        pipe_errors);
        advance_model();
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        instr_fields_t f;
        seed          = 32'h9be9;
        clk           = 1'b0;
        arst_n        = 1'b1;
        instr         = '0;
        cmp           = '0;
        flush         = '0;
        stall         = '0;
        exp_e         = '0;
        exp_m         = '0;
        exp_w         = '0;
        plain_run     = 0;
        decode_errors = 0;
        pipe_errors   = 0;
        reset_errors  = 0;
        build_table();
        #1;
        arst_n = 1'b0;
        #4;
        check_field("e_ctrl in reset", 32'd0, 32'(e_ctrl), reset_errors);
        check_field("m_ctrl in reset", 32'd0, 32'(m_ctrl), reset_errors);
        check_field("w_ctrl in reset", 32'd0, 32'(w_ctrl), reset_errors);
        repeat (NUM_RESET) @(posedge clk);
        #2;
        arst_n = 1'b1;
        foreach (enc_table[i])
        begin
            drive_cycle(enc_table[i], 1'b0); // Every encoding once, no strobes
            @(posedge clk);
            #2;
        end
        repeat (NUM_RANDOM)
        begin
            pick_instr(f);
            drive_cycle(f, 1'b1);
            @(posedge clk);
            #2;
        end
        flush = '0;
        stall = '0;
        repeat (NUM_DRAIN) @(posedge clk);
        @(negedge clk);
        #1;
        $display("Errors: decode %0d, pipeline %0d, reset %0d",
                 decode_errors, pipe_errors, reset_errors);
        if (decode_errors + pipe_errors + reset_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- src.f
cpu_ctrl_pkg.sv
instr_decoder.sv
flow_decoder.sv
branch_resolve.sv
ctrl_pipeline.sv
controller.sv
tb_controller_sva.sv
tb_controller.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_controller
FILELIST  = src.f
OBJDIR    = obj_dir
LOG       = sim.log

SOURCES   = $(shell grep -v '^+' $(FILELIST))
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
